//--- design/shiftPkg.sv
// shift unit shared definitions
// operand word, signed shift count and op code with its flag positions
`default_nettype none

package shiftPkg;

	// operand and result word
	typedef logic [63:0] dataT;

	// signed shift count, negative means a right shift
	typedef logic signed [7:0] countT;

	// op code, one flag per bit
	typedef logic [2:0] shiftOpT;

	// set for zero fill and zero extension, clear for arithmetic
	localparam int OpLogical = 0;

	// set for 64-bit mode, clear for 32-bit mode
	localparam int OpQuad = 1;

	// count taken as unsigned, always a right shift
	localparam int OpForceRight = 2;

endpackage

`default_nettype wire

//--- design/barrelShifter.sv
// barrel shifter for 64-bit and 32-bit arithmetic and logical shifts
// staged 32/16/8/4/2/1 network, direction from the count sign or the forceRight flag
`timescale 1ns/1ps
`default_nettype none

module barrelShifter (
	input  wire shiftPkg::dataT    value,
	input  wire shiftPkg::countT   count,
	input  wire shiftPkg::shiftOpT op,
	output shiftPkg::dataT         result
);

	logic isLogical;
	logic isQuad;
	logic isForce;
	logic isRight;
	logic [7:0] negCount;
	logic [5:0] amount;
	shiftPkg::dataT fill;
	shiftPkg::dataT work;
	shiftPkg::dataT s32;
	shiftPkg::dataT s16;
	shiftPkg::dataT s8;
	shiftPkg::dataT s4;
	shiftPkg::dataT s2;
	shiftPkg::dataT s1;

	assign isLogical = op[shiftPkg::OpLogical];
	assign isQuad = op[shiftPkg::OpQuad];
	assign isForce = op[shiftPkg::OpForceRight];
	assign isRight = count[7] || isForce;

	always_comb
	begin
		negCount = -count;
		// forced right uses the raw count, a negative count its magnitude
		if (isForce || !count[7])
			amount = count[5:0];
		else
			amount = negCount[5:0];

		if (isQuad)
		begin
			fill = (!isLogical && value[63]) ? '1 : '0;
			work = value;
		end
		else
		begin
			// 32-bit mode works on the low word with an extended upper half
			fill = (!isLogical && value[31]) ? '1 : '0;
			work = {fill[31:0], value[31:0]};
			amount[5] = 1'b0;
		end

		if (isRight)
		begin
			s32 = amount[5] ? {fill[31:0], work[63:32]} : work;
			s16 = amount[4] ? {fill[15:0], s32[63:16]} : s32;
			s8 = amount[3] ? {fill[7:0], s16[63:8]} : s16;
			s4 = amount[2] ? {fill[3:0], s8[63:4]} : s8;
			s2 = amount[1] ? {fill[1:0], s4[63:2]} : s4;
			s1 = amount[0] ? {fill[0], s2[63:1]} : s2;
		end
		else
		begin
			s32 = amount[5] ? {work[31:0], 32'h0} : work;
			s16 = amount[4] ? {s32[47:0], 16'h0} : s32;
			s8 = amount[3] ? {s16[55:0], 8'h0} : s16;
			s4 = amount[2] ? {s8[59:0], 4'h0} : s8;
			s2 = amount[1] ? {s4[61:0], 2'h0} : s4;
			s1 = amount[0] ? {s2[62:0], 1'b0} : s2;
		end

		result = s1;
		// extend the 32-bit result from bit 31
		if (!isQuad)
			result[63:32] = (s1[31] && !isLogical) ? 32'hFFFF_FFFF : 32'h0;
	end

endmodule

`default_nettype wire

//--- design/shiftLane.sv
// one shift lane
// holds a request, registers the shifted result and offers it until released
`timescale 1ns/1ps
`default_nettype none

module shiftLane (
	input  wire                    clock,
	input  wire                    rstN,
	input  wire                    load,
	input  wire shiftPkg::dataT    data,
	input  wire shiftPkg::countT   count,
	input  wire shiftPkg::shiftOpT op,
	input  wire                    clear,
	output logic                   busy,
	output logic                   done,
	output shiftPkg::dataT         result
);

	shiftPkg::dataT dataR;
	shiftPkg::countT countR;
	shiftPkg::shiftOpT opR;
	shiftPkg::dataT shifted;

	barrelShifter shifter0 (
		.value  (dataR),
		.count  (countR),
		.op     (opR),
		.result (shifted)
	);

	// operand capture on load
	always_ff @(posedge clock)
	begin
		if (load)
		begin
			dataR <= data;
			countR <= count;
			opR <= op;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			done <= 1'b0;
		end
		else if (clear)
		begin
			busy <= 1'b0;
			done <= 1'b0;
		end
		else if (load)
			busy <= 1'b1;
		else if (busy && !done)
			done <= 1'b1;
	end

	// result taken one clock after the operands
	always_ff @(posedge clock)
	begin
		if (busy && !done)
			result <= shifted;
	end

endmodule

`default_nettype wire

//--- design/laneDispatcher.sv
// request intake with four-phase req/ack
// hands each request to the lane at a round-robin issue pointer
`timescale 1ns/1ps
`default_nettype none

module laneDispatcher #(
	parameter int NumLanes = 4
) (
	input  wire                    clock,
	input  wire                    rstN,
	input  wire                    inReq,
	input  wire shiftPkg::dataT    inData,
	input  wire shiftPkg::countT   inCount,
	input  wire shiftPkg::shiftOpT inOp,
	output logic                   inAck,
	input  wire [NumLanes-1:0]     laneBusy,
	output logic [NumLanes-1:0]    laneLoad,
	output shiftPkg::dataT         laneData,
	output shiftPkg::countT        laneCount,
	output shiftPkg::shiftOpT      laneOp
);

	localparam int IdxW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

	typedef enum logic {
		Idle,
		Acked
	} stateT;

	stateT state;
	logic [IdxW-1:0] issuePtr;
	logic accept;

	// only the lane at the pointer may take the request
	assign accept = (state == Idle) && inReq && !laneBusy[issuePtr];
	assign inAck = (state == Acked);

	// operands are stable while inReq is high
	assign laneData = inData;
	assign laneCount = inCount;
	assign laneOp = inOp;

	always_comb
	begin
		laneLoad = '0;
		laneLoad[issuePtr] = accept;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= Idle;
			issuePtr <= '0;
		end
		else
		begin
			case (state)
				Idle:
				begin
					if (accept)
					begin
						state <= Acked;
						issuePtr <= (issuePtr == IdxW'(NumLanes - 1)) ? '0 : issuePtr + 1'b1;
					end
				end
				// hold ack until the producer lets go
				Acked:
				begin
					if (!inReq)
						state <= Idle;
				end
				default: state <= Idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/resultCollector.sv
// in-order result drain with four-phase req/ack output
// follows the issue order of the dispatcher and releases each lane once taken
`timescale 1ns/1ps
`default_nettype none

module resultCollector #(
	parameter int NumLanes = 4
) (
	input  wire                                 clock,
	input  wire                                 rstN,
	input  wire [NumLanes-1:0]                  laneDone,
	input  wire shiftPkg::dataT [NumLanes-1:0]  laneResult,
	output logic [NumLanes-1:0]                 laneRelease,
	output logic                                outReq,
	output shiftPkg::dataT                      outData,
	input  wire                                 outAck
);

	localparam int IdxW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

	typedef enum logic [1:0] {
		Idle,
		Present,
		Finish
	} stateT;

	stateT state;
	logic [IdxW-1:0] drainPtr;
	logic ready;

	// a lane still being released does not count as done
	assign ready = laneDone[drainPtr] && !laneRelease[drainPtr];
	assign outReq = (state == Present);

	// outData held from here until the next result
	always_ff @(posedge clock)
	begin
		if (state == Idle && ready)
			outData <= laneResult[drainPtr];
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= Idle;
			drainPtr <= '0;
			laneRelease <= '0;
		end
		else
		begin
			laneRelease <= '0;
			case (state)
				Idle:
					if (ready)
						state <= Present;
				Present:
					if (outAck)
						state <= Finish;
				Finish:
				begin
					if (!outAck)
					begin
						state <= Idle;
						laneRelease[drainPtr] <= 1'b1;
						drainPtr <= (drainPtr == IdxW'(NumLanes - 1)) ? '0 : drainPtr + 1'b1;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/shiftUnitTop.sv
// shift execution subsystem top level
// dispatcher, a row of identical shift lanes and the in-order collector
`timescale 1ns/1ps
`default_nettype none

module shiftUnitTop #(
	parameter int NumLanes = 4
) (
	input  wire                    clock,
	input  wire                    rstN,
	input  wire                    inReq,
	input  wire shiftPkg::dataT    inData,
	input  wire shiftPkg::countT   inCount,
	input  wire shiftPkg::shiftOpT inOp,
	output wire                    inAck,
	output wire                    outReq,
	output shiftPkg::dataT         outData,
	input  wire                    outAck
);

	wire [NumLanes-1:0] laneLoad;
	wire [NumLanes-1:0] laneBusy;
	wire [NumLanes-1:0] laneDone;
	wire [NumLanes-1:0] laneRelease;
	wire shiftPkg::dataT [NumLanes-1:0] laneResult;
	wire shiftPkg::dataT laneData;
	wire shiftPkg::countT laneCount;
	wire shiftPkg::shiftOpT laneOp;

	laneDispatcher #(
		.NumLanes (NumLanes)
	) dispatcher0 (
		.clock     (clock),
		.rstN      (rstN),
		.inReq     (inReq),
		.inData    (inData),
		.inCount   (inCount),
		.inOp      (inOp),
		.inAck     (inAck),
		.laneBusy  (laneBusy),
		.laneLoad  (laneLoad),
		.laneData  (laneData),
		.laneCount (laneCount),
		.laneOp    (laneOp)
	);

	// all lanes share the operand bus, each has its own load
	for (genvar i = 0; i < NumLanes; i++)
	begin : gLane
		shiftLane lane (
			.clock  (clock),
			.rstN   (rstN),
			.load   (laneLoad[i]),
			.data   (laneData),
			.count  (laneCount),
			.op     (laneOp),
			.clear  (laneRelease[i]),
			.busy   (laneBusy[i]),
			.done   (laneDone[i]),
			.result (laneResult[i])
		);
	end

	resultCollector #(
		.NumLanes (NumLanes)
	) collector0 (
		.clock       (clock),
		.rstN        (rstN),
		.laneDone    (laneDone),
		.laneResult  (laneResult),
		.laneRelease (laneRelease),
		.outReq      (outReq),
		.outData     (outData),
		.outAck      (outAck)
	);

endmodule

`default_nettype wire

//--- tests/tbClock.sv
// testbench clock source
// free-running clock with a 4 ns period
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int HalfPeriod = 2
) (
	output logic clock
);

	initial
	begin
		clock = 1'b0;
		forever #(HalfPeriod) clock = ~clock;
	end

endmodule

`default_nettype wire

//--- tests/shiftUnit_assertions.sv
// handshake protocol checks for the shift unit top level
// attached to every shiftUnitTop instance with bind
`timescale 1ns/1ps
`default_nettype none

module shiftUnitAssertions (
	input wire                 clock,
	input wire                 rstN,
	input wire                 inReq,
	input wire                 inAck,
	input wire                 outReq,
	input wire                 outAck,
	input wire shiftPkg::dataT outData
);

	// ack follows a request that was seen high
	inAckNeedsReq: assert property (@(posedge clock) disable iff (!rstN)
		$rose(inAck) |-> $past(inReq))
		else $error("inAck rose without a pending inReq");

	outDataStable: assert property (@(posedge clock) disable iff (!rstN)
		outReq |=> (!outReq || $stable(outData)))
		else $error("outData changed while outReq was high");

	// req may only drop once the consumer has acknowledged
	outReqFallAfterAck: assert property (@(posedge clock) disable iff (!rstN)
		$fell(outReq) |-> $past(outAck))
		else $error("outReq fell before outAck was seen high");

endmodule

bind shiftUnitTop shiftUnitAssertions assert0 (
	.clock   (clock),
	.rstN    (rstN),
	.inReq   (inReq),
	.inAck   (inAck),
	.outReq  (outReq),
	.outAck  (outAck),
	.outData (outData)
);

`default_nettype wire

//--- tests/shiftUnitTb.sv
// shift unit testbench
// feeds a table of shifts through the intake and checks results in submit order
`timescale 1ns/1ps
`default_nettype none

module shiftUnitTb;

	localparam int NumLanes = 4;
	localparam int WaitLimit = 200;

	wire clock;
	logic rstN;
	logic inReq;
	shiftPkg::dataT inData;
	shiftPkg::countT inCount;
	shiftPkg::shiftOpT inOp;
	wire inAck;
	wire outReq;
	wire shiftPkg::dataT outData;
	logic outAck;
	integer seed;

	// stimulus table, one column per queue
	shiftPkg::dataT tblData[$];
	shiftPkg::countT tblCount[$];
	shiftPkg::shiftOpT tblOp[$];
	shiftPkg::dataT tblExp[$];
	shiftPkg::dataT expectedQ[$];

	tbClock clockGen0 (
		.clock (clock)
	);

	shiftUnitTop #(
		.NumLanes (NumLanes)
	) dut0 (
		.clock   (clock),
		.rstN    (rstN),
		.inReq   (inReq),
		.inData  (inData),
		.inCount (inCount),
		.inOp    (inOp),
		.inAck   (inAck),
		.outReq  (outReq),
		.outData (outData),
		.outAck  (outAck)
	);

	task stopOnError();
		$display("Finished with errors");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task checkData(input string name, input shiftPkg::dataT got, input shiftPkg::dataT exp);
		if (got !== exp)
		begin
			$display("ERR time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
			stopOnError();
		end
	endtask

	task checkLevel(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERR time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
			stopOnError();
		end
	endtask

	task waitInAck(input logic level);
		int cycles;
		cycles = 0;
		while (inAck !== level)
		begin
			@(negedge clock);
			cycles++;
			if (cycles > WaitLimit)
			begin
				$display("Timed out waiting for inAck to become %0b", level);
				stopOnError();
			end
		end
	endtask

	task waitOutReq(input logic level);
		int cycles;
		cycles = 0;
		while (outReq !== level)
		begin
			@(negedge clock);
			cycles++;
			if (cycles > WaitLimit)
			begin
				$display("Timed out waiting for outReq to become %0b", level);
				stopOnError();
			end
		end
	endtask

	task addEntry(input shiftPkg::dataT d, input shiftPkg::countT c,
			input shiftPkg::shiftOpT o, input shiftPkg::dataT e);
		tblData.push_back(d);
		tblCount.push_back(c);
		tblOp.push_back(o);
		tblExp.push_back(e);
	endtask

	// op bits are forceRight, quad, logical from high to low
	task loadTable();
		addEntry(64'h0000_0000_0000_0001, 8'd0, 3'b010, 64'h0000_0000_0000_0001);
		addEntry(64'h0000_0000_0000_0001, 8'd63, 3'b010, 64'h8000_0000_0000_0000);
		addEntry(64'h0123_4567_89AB_CDEF, 8'd4, 3'b010, 64'h1234_5678_9ABC_DEF0);
		addEntry(64'h8000_0000_0000_0000, 8'hFC, 3'b010, 64'hF800_0000_0000_0000);
		addEntry(64'h8000_0000_0000_0000, 8'hFC, 3'b011, 64'h0800_0000_0000_0000);
		addEntry(64'hFFFF_FFFF_FFFF_FFFF, 8'hC1, 3'b011, 64'h0000_0000_0000_0001);
		addEntry(64'h8000_0000_0000_0000, 8'hC1, 3'b010, 64'hFFFF_FFFF_FFFF_FFFF);
		// 32-bit mode, upper word ignored
		addEntry(64'hDEAD_BEEF_0000_0001, 8'd31, 3'b000, 64'hFFFF_FFFF_8000_0000);
		addEntry(64'hDEAD_BEEF_0000_0001, 8'd31, 3'b001, 64'h0000_0000_8000_0000);
		addEntry(64'hFFFF_FFFF_1234_5678, 8'd36, 3'b001, 64'h0000_0000_2345_6780);
		addEntry(64'h0000_0000_8000_0000, 8'hFC, 3'b000, 64'hFFFF_FFFF_F800_0000);
		// forced right, count read as unsigned
		addEntry(64'h8000_0000_0000_0000, 8'd4, 3'b110, 64'hF800_0000_0000_0000);
		addEntry(64'hF000_0000_0000_0000, 8'hC4, 3'b111, 64'h0F00_0000_0000_0000);
		addEntry(64'hFFFF_FFFF_8000_0000, 8'd33, 3'b101, 64'h0000_0000_4000_0000);
		addEntry(64'hFFFF_FFFF_8000_0000, 8'd33, 3'b100, 64'hFFFF_FFFF_C000_0000);
	endtask

	task sendRequests();
		for (int i = 0; i < tblData.size(); i++)
		begin
			inData = tblData[i];
			inCount = tblCount[i];
			inOp = tblOp[i];
			inReq = 1'b1;
			waitInAck(1'b1);
			expectedQ.push_back(tblExp[i]);
			inReq = 1'b0;
			waitInAck(1'b0);
		end
	endtask

	task takeResults();
		int delay;
		for (int j = 0; j < tblData.size(); j++)
		begin
			waitOutReq(1'b1);
			if (expectedQ.size() == 0)
			begin
				$display("A result came out with no request pending");
				stopOnError();
			end
			checkData("outData", outData, expectedQ.pop_front());
			// later results are taken slowly so the lanes fill up
			if (j >= NumLanes)
			begin
				delay = $unsigned($random(seed)) % 13;
				repeat (delay) @(negedge clock);
			end
			outAck = 1'b1;
			waitOutReq(1'b0);
			outAck = 1'b0;
		end
	endtask

	initial
	begin
		seed = 62;
		rstN = 1'b0;
		inReq = 1'b0;
		inData = '0;
		inCount = '0;
		inOp = '0;
		outAck = 1'b0;
		loadTable();
		repeat (10) @(negedge clock);
		rstN = 1'b1;
		@(negedge clock);
		checkLevel("inAck", inAck, 1'b0);
		checkLevel("outReq", outReq, 1'b0);
		fork
			sendRequests();
			takeResults();
		join
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- shiftUnit.f
design/shiftPkg.sv
design/barrelShifter.sv
design/shiftLane.sv
design/laneDispatcher.sv
design/resultCollector.sv
design/shiftUnitTop.sv
tests/tbClock.sv
tests/shiftUnit_assertions.sv
tests/shiftUnitTb.sv
